/* rtl/dccm_geom_pkg.sv */
// DCCM geometry constants, address/data types and address field helpers
package dccm_geom_pkg;

   // Byte offset within a bank word
   localparam int DCCM_WIDTH_BITS = 2;
   // Bank select field sits right above the byte offset
   localparam int DCCM_BANK_BITS = 3;
   localparam int DCCM_NUM_BANKS = 1 << DCCM_BANK_BITS;
   // Rows per bank, shrunk for simulation
   localparam int DCCM_INDEX_BITS = 6;
   localparam int DCCM_INDEX_DEPTH = 1 << DCCM_INDEX_BITS;
   localparam int DCCM_BITS = DCCM_WIDTH_BITS + DCCM_BANK_BITS + DCCM_INDEX_BITS;
   // 32 data bits plus 7 check bits
   localparam int DCCM_FDATA_WIDTH = 39;

   // Lowest bit of the row field
   localparam int DCCM_ROW_LSB = DCCM_WIDTH_BITS + DCCM_BANK_BITS;

   typedef logic [DCCM_BITS-1:0] dccm_addr_t;
   typedef logic [DCCM_BANK_BITS-1:0] dccm_bank_t;
   typedef logic [DCCM_INDEX_BITS-1:0] dccm_row_t;
   typedef logic [DCCM_FDATA_WIDTH-1:0] dccm_data_t;

   // Bank field of a byte address
   function automatic dccm_bank_t bank_of(input dccm_addr_t addr);
      return addr[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   endfunction

   // Row field of a byte address
   function automatic dccm_row_t row_of(input dccm_addr_t addr);
      return addr[DCCM_ROW_LSB +: DCCM_INDEX_BITS];
   endfunction

   // Next bank up, wrapping from the last bank to bank 0
   function automatic dccm_bank_t next_bank(input dccm_bank_t bank);
      return dccm_bank_t'(bank + 1'b1);
   endfunction

endpackage

/* rtl/dccm_op_pkg.sv */
// Per-bank operation encoding
package dccm_op_pkg;

   // What a single bank does in one cycle
   typedef enum logic [1:0] {
      bank_idle  = 2'd0,
      bank_read  = 2'd1,
      bank_write = 2'd2
   } bank_op_e;

endpackage

/* rtl/dccm_steer_if.sv */
// Per-bank request bus from the write and read steering to the bank array
interface dccm_steer_if
   import dccm_geom_pkg::*;
   ();

   // Write side, one entry per bank
   logic [DCCM_NUM_BANKS-1:0] wr_en;
   dccm_row_t                 wr_row  [DCCM_NUM_BANKS];
   dccm_data_t                wr_data [DCCM_NUM_BANKS];

   // Read side, one entry per bank
   logic [DCCM_NUM_BANKS-1:0] rd_en;
   dccm_row_t                 rd_row  [DCCM_NUM_BANKS];

   // Banks of the last read, for aligning the RAM outputs
   dccm_bank_t lo_bank_q;
   dccm_bank_t hi_bank_q;

   modport wr_src (output wr_en, output wr_row, output wr_data);

   modport rd_src (output rd_en, output rd_row, output lo_bank_q, output hi_bank_q);

   modport array (
      input wr_en, input wr_row, input wr_data,
      input rd_en, input rd_row, input lo_bank_q, input hi_bank_q
   );

endinterface

/* rtl/dccm_wr_steer.sv */
// Write steering: lo/hi write split into per-bank enables, rows and data
module dccm_wr_steer
   import dccm_geom_pkg::*;
(
   input  logic       wren,
   input  dccm_addr_t wr_addr_lo,
   input  dccm_addr_t wr_addr_hi,
   input  dccm_data_t wr_data_lo,
   input  dccm_data_t wr_data_hi,
   dccm_steer_if.wr_src steer
);

   dccm_bank_t lo_bank;
   dccm_bank_t hi_bank;
   logic       unaligned;

   assign lo_bank   = bank_of(wr_addr_lo);
   assign hi_bank   = bank_of(wr_addr_hi);
   // Halves in different banks means the store crosses a word boundary
   assign unaligned = (lo_bank != hi_bank);

   for (genvar b = 0; b < DCCM_NUM_BANKS; b++) begin : g_bank
      logic hit_lo;
      logic hit_hi;
      logic use_hi;

      assign hit_lo = (lo_bank == dccm_bank_t'(b));
      assign hit_hi = (hi_bank == dccm_bank_t'(b));
      // Hi only owns the bank when the access is split
      assign use_hi = hit_hi & unaligned;

      assign steer.wr_en[b]   = wren & (hit_lo | hit_hi);
      assign steer.wr_row[b]  = use_hi ? row_of(wr_addr_hi) : row_of(wr_addr_lo);
      assign steer.wr_data[b] = use_hi ? wr_data_hi : wr_data_lo;
   end : g_bank

   // A split store must land in two neighbouring banks
   always_comb begin
      if (wren && unaligned) begin
         assert final (hi_bank == next_bank(lo_bank))
            else $error("split write hi bank %0d does not follow lo bank %0d",
                        hi_bank, lo_bank);
      end
   end

endmodule

/* rtl/dccm_rd_steer.sv */
// Read steering: per-bank read enables and rows, registered lo/hi bank indices
module dccm_rd_steer
   import dccm_geom_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rden,
   input  dccm_addr_t rd_addr_lo,
   input  dccm_addr_t rd_addr_hi,
   dccm_steer_if.rd_src steer
);

   dccm_bank_t lo_bank;
   dccm_bank_t hi_bank;
   logic       unaligned;

   assign lo_bank   = bank_of(rd_addr_lo);
   assign hi_bank   = bank_of(rd_addr_hi);
   assign unaligned = (lo_bank != hi_bank);

   for (genvar b = 0; b < DCCM_NUM_BANKS; b++) begin : g_bank
      logic hit_lo;
      logic hit_hi;
      logic use_hi;

      assign hit_lo = (lo_bank == dccm_bank_t'(b));
      assign hit_hi = (hi_bank == dccm_bank_t'(b));
      assign use_hi = hit_hi & unaligned;

      assign steer.rd_en[b]  = rden & (hit_lo | hit_hi);
      assign steer.rd_row[b] = use_hi ? row_of(rd_addr_hi) : row_of(rd_addr_lo);
   end : g_bank

   // Bank indices follow the RAM read latency
   // Captured every cycle, the outputs only matter after a read
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         steer.lo_bank_q <= '0;
         steer.hi_bank_q <= '0;
      end else begin
         steer.lo_bank_q <= lo_bank;
         steer.hi_bank_q <= hi_bank;
      end
   end

   // One read touches the lo bank and at most one neighbour
   a_rd_two_banks: assert property (
      @(posedge clk) disable iff (!rst_n) $countones(steer.rd_en) <= 2
   ) else $error("read enables more than two banks");

endmodule

/* rtl/dccm_ram_bank.sv */
// Single-port synchronous bank RAM with registered read data
module dccm_ram_bank
   import dccm_geom_pkg::*;
   import dccm_op_pkg::*;
(
   input  logic       clk,
   input  bank_op_e   op,
   input  dccm_row_t  row,
   input  dccm_data_t wdata,
   output dccm_data_t rdata
);

   dccm_data_t mem [DCCM_INDEX_DEPTH];

   // Read data only changes on a read, so it holds through idle cycles
   always_ff @(posedge clk) begin
      case (op)
         bank_write: begin
            mem[row] <= wdata;
         end
         bank_read: begin
            rdata <= mem[row];
         end
         default: begin
         end
      endcase
   end

endmodule

/* rtl/dccm_bank_array.sv */
// Bank array: per-bank op and row select, bank RAMs, lo/hi read data alignment
module dccm_bank_array
   import dccm_geom_pkg::*;
   import dccm_op_pkg::*;
(
   input  logic       clk,
   dccm_steer_if.array steer,
   output dccm_data_t rd_data_lo,
   output dccm_data_t rd_data_hi
);

   dccm_data_t bank_dout [DCCM_NUM_BANKS];

   for (genvar b = 0; b < DCCM_NUM_BANKS; b++) begin : g_bank
      bank_op_e  op;
      dccm_row_t row;

      // Store wins over load on the same bank
      always_comb begin
         if (steer.wr_en[b]) begin
            op = bank_write;
         end else if (steer.rd_en[b]) begin
            op = bank_read;
         end else begin
            op = bank_idle;
         end
      end

      assign row = steer.wr_en[b] ? steer.wr_row[b] : steer.rd_row[b];

      dccm_ram_bank i_ram (
         .clk   (clk),
         .op    (op),
         .row   (row),
         .wdata (steer.wr_data[b]),
         .rdata (bank_dout[b])
      );
   end : g_bank

   // Realign bank outputs using the indices captured with the read
   assign rd_data_lo = bank_dout[steer.lo_bank_q];
   assign rd_data_hi = bank_dout[steer.hi_bank_q];

   // Write steering must never open more than a lo/hi pair
   a_wr_two_banks: assert property (
      @(posedge clk) $countones(steer.wr_en) <= 2
   ) else $error("write enables more than two banks");

endmodule

/* rtl/lsu_dccm_mem.sv */
// LSU data memory top: write/read steering and banked RAM array
module lsu_dccm_mem
   import dccm_geom_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   // Store port, hi used only when the store spans two banks
   input  logic       wren,
   input  dccm_addr_t wr_addr_lo,
   input  dccm_addr_t wr_addr_hi,
   input  dccm_data_t wr_data_lo,
   input  dccm_data_t wr_data_hi,

   // Load port, data returned one cycle after rden
   input  logic       rden,
   input  dccm_addr_t rd_addr_lo,
   input  dccm_addr_t rd_addr_hi,
   output dccm_data_t rd_data_lo,
   output dccm_data_t rd_data_hi
);

   dccm_steer_if steer_bus ();

   dccm_wr_steer i_wr_steer (
      .wren       (wren),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .steer      (steer_bus.wr_src)
   );

   dccm_rd_steer i_rd_steer (
      .clk        (clk),
      .rst_n      (rst_n),
      .rden       (rden),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .steer      (steer_bus.rd_src)
   );

   dccm_bank_array i_bank_array (
      .clk        (clk),
      .steer      (steer_bus.array),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

endmodule

/* bench/lsu_dccm_mem_tb.sv */
// Testbench for the LSU data memory: step table, LFSR write data, bank reference model
module lsu_dccm_mem_tb
   import dccm_geom_pkg::*;
   import dccm_op_pkg::*;
();

   localparam logic [31:0] LFSR_SEED = 32'hfa96_f4ea;
   localparam int DRAIN_LIMIT = 8;

   // One table row is one clock cycle of stimulus
   typedef struct {
      logic       wr;
      dccm_addr_t wr_lo;
      dccm_addr_t wr_hi;
      logic       rd;
      dccm_addr_t rd_lo;
      dccm_addr_t rd_hi;
   } step_t;

   logic       clk;
   logic       rst_n;
   logic       wren;
   logic       rden;
   dccm_addr_t wr_addr_lo;
   dccm_addr_t wr_addr_hi;
   dccm_data_t wr_data_lo;
   dccm_data_t wr_data_hi;
   dccm_addr_t rd_addr_lo;
   dccm_addr_t rd_addr_hi;
   dccm_data_t rd_data_lo;
   dccm_data_t rd_data_hi;

   step_t      steps [$];
   dccm_data_t model_mem [DCCM_NUM_BANKS][DCCM_INDEX_DEPTH];
   logic [31:0] lfsr;
   logic       pending;
   dccm_data_t exp_lo;
   dccm_data_t exp_hi;
   int         checks;
   int         errors;

   lsu_dccm_mem dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .wren       (wren),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .rden       (rden),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] stepped;
      stepped = state >> 1;
      if (state[0]) begin
         stepped = stepped ^ 32'h8020_0003;
      end
      return stepped;
   endfunction

   // One LFSR step per data bit
   task automatic random_word(output dccm_data_t word);
      for (int i = 0; i < DCCM_FDATA_WIDTH; i++) begin
         word[i] = lfsr[0];
         lfsr = lfsr_step(lfsr);
      end
   endtask

   function automatic dccm_bank_t bank_field(input dccm_addr_t a);
      return a[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   endfunction

   function automatic dccm_row_t row_field(input dccm_addr_t a);
      return a[DCCM_WIDTH_BITS + DCCM_BANK_BITS +: DCCM_INDEX_BITS];
   endfunction

   function automatic dccm_addr_t addr_at(input dccm_row_t row, input dccm_bank_t bank,
                                          input logic [DCCM_WIDTH_BITS-1:0] off);
      return {row, bank, off};
   endfunction

   function automatic step_t make_step(input logic wr, input dccm_addr_t wr_lo,
                                       input dccm_addr_t wr_hi, input logic rd,
                                       input dccm_addr_t rd_lo, input dccm_addr_t rd_hi);
      step_t s;
      s.wr    = wr;
      s.wr_lo = wr_lo;
      s.wr_hi = wr_hi;
      s.rd    = rd;
      s.rd_lo = rd_lo;
      s.rd_hi = rd_hi;
      return s;
   endfunction

   task automatic build_table();
      // Aligned write and read back
      steps.push_back(make_step(1'b1, addr_at(6'd5, 3'd1, 2'd0), addr_at(6'd5, 3'd1, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd5, 3'd1, 2'd0), addr_at(6'd5, 3'd1, 2'd0)));
      // Split across banks 2 and 3
      steps.push_back(make_step(1'b1, addr_at(6'd9, 3'd2, 2'd1), addr_at(6'd9, 3'd3, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd9, 3'd2, 2'd1), addr_at(6'd9, 3'd3, 2'd0)));
      // Bank 7 wraps to bank 0 on the next row
      steps.push_back(make_step(1'b1, addr_at(6'd10, 3'd7, 2'd3), addr_at(6'd11, 3'd0, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd10, 3'd7, 2'd3), addr_at(6'd11, 3'd0, 2'd0)));
      // Hi word must sit in the hi row of bank 0
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd11, 3'd0, 2'd0), addr_at(6'd11, 3'd0, 2'd0)));
      // Three rows of bank 4, then back-to-back reads
      steps.push_back(make_step(1'b1, addr_at(6'd20, 3'd4, 2'd0), addr_at(6'd20, 3'd4, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b1, addr_at(6'd21, 3'd4, 2'd0), addr_at(6'd21, 3'd4, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b1, addr_at(6'd22, 3'd4, 2'd0), addr_at(6'd22, 3'd4, 2'd0),
                                1'b0, '0, '0));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd20, 3'd4, 2'd0), addr_at(6'd20, 3'd4, 2'd0)));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd21, 3'd4, 2'd0), addr_at(6'd21, 3'd4, 2'd0)));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd22, 3'd4, 2'd0), addr_at(6'd22, 3'd4, 2'd0)));
      // Write and read together on disjoint banks
      steps.push_back(make_step(1'b1, addr_at(6'd30, 3'd6, 2'd2), addr_at(6'd30, 3'd7, 2'd0),
                                1'b1, addr_at(6'd9, 3'd2, 2'd1), addr_at(6'd9, 3'd3, 2'd0)));
      steps.push_back(make_step(1'b1, addr_at(6'd5, 3'd1, 2'd0), addr_at(6'd5, 3'd1, 2'd0),
                                1'b1, addr_at(6'd30, 3'd6, 2'd2), addr_at(6'd30, 3'd7, 2'd0)));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd5, 3'd1, 2'd0), addr_at(6'd5, 3'd1, 2'd0)));
      steps.push_back(make_step(1'b1, addr_at(6'd40, 3'd2, 2'd0), addr_at(6'd40, 3'd2, 2'd0),
                                1'b1, addr_at(6'd10, 3'd7, 2'd3), addr_at(6'd11, 3'd0, 2'd0)));
      steps.push_back(make_step(1'b0, '0, '0,
                                1'b1, addr_at(6'd40, 3'd2, 2'd0), addr_at(6'd40, 3'd2, 2'd0)));
   endtask

   task automatic check_data(input string what, input dccm_data_t got, input dccm_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, what, exp, got);
      end
   endtask

   // Result of the read sampled at the last edge
   task automatic collect_read();
      if (pending) begin
         check_data("rd_data_lo", rd_data_lo, exp_lo);
         check_data("rd_data_hi", rd_data_hi, exp_hi);
         pending = 1'b0;
      end
   endtask

   task automatic apply_step(input step_t s);
      dccm_data_t d_lo;
      dccm_data_t d_hi;
      d_lo = '0;
      d_hi = '0;
      if (s.wr) begin
         random_word(d_lo);
         random_word(d_hi);
      end
      wren       = s.wr;
      wr_addr_lo = s.wr_lo;
      wr_addr_hi = s.wr_hi;
      wr_data_lo = d_lo;
      wr_data_hi = d_hi;
      rden       = s.rd;
      rd_addr_lo = s.rd_lo;
      rd_addr_hi = s.rd_hi;
      // Prediction uses the model before this cycle's write
      if (s.rd) begin
         exp_lo = model_mem[bank_field(s.rd_lo)][row_field(s.rd_lo)];
         if (bank_field(s.rd_lo) != bank_field(s.rd_hi)) begin
            exp_hi = model_mem[bank_field(s.rd_hi)][row_field(s.rd_hi)];
         end else begin
            exp_hi = exp_lo;
         end
         pending = 1'b1;
      end
      if (s.wr) begin
         model_mem[bank_field(s.wr_lo)][row_field(s.wr_lo)] = d_lo;
         if (bank_field(s.wr_lo) != bank_field(s.wr_hi)) begin
            model_mem[bank_field(s.wr_hi)][row_field(s.wr_hi)] = d_hi;
         end
      end
   endtask

   task automatic wait_cycles(input int n);
      for (int c = 0; c < n; c++) begin
         @(posedge clk);
      end
   endtask

   initial begin
      int waited;
      rst_n      = 1'b0;
      wren       = 1'b0;
      rden       = 1'b0;
      wr_addr_lo = '0;
      wr_addr_hi = '0;
      wr_data_lo = '0;
      wr_data_hi = '0;
      rd_addr_lo = '0;
      rd_addr_hi = '0;
      lfsr       = LFSR_SEED;
      pending    = 1'b0;
      exp_lo     = '0;
      exp_hi     = '0;
      checks     = 0;
      errors     = 0;
      build_table();
      wait_cycles(5);
      #1;
      rst_n = 1'b1;
      foreach (steps[i]) begin
         @(posedge clk);
         #1;
         collect_read();
         apply_step(steps[i]);
      end
      // Drain the last read with idle inputs
      waited = 0;
      while (pending && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         #1;
         collect_read();
         apply_step(make_step(1'b0, '0, '0, 1'b0, '0, '0));
         waited++;
      end
      if (pending) begin
         $display("Timed out waiting for the last read result");
         $display("Something failed");
      end else begin
         $display("Checks %0d, errors %0d", checks, errors);
         if (errors == 0) begin
            $display("Everything OK");
         end else begin
            $display("Something failed");
         end
      end
      $finish;
   end

endmodule

/* lsu_dccm_mem.f */
rtl/dccm_geom_pkg.sv
rtl/dccm_op_pkg.sv
rtl/dccm_steer_if.sv
rtl/dccm_wr_steer.sv
rtl/dccm_rd_steer.sv
rtl/dccm_ram_bank.sv
rtl/dccm_bank_array.sv
rtl/lsu_dccm_mem.sv
bench/lsu_dccm_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f lsu_dccm_mem.f --top-module lsu_dccm_mem_tb -o sim_tb
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Everything OK"
